//--- ic_addr_decode.sv
// address is held from accept until the next accept; no translation, the address is physical
`timescale 1ns/1ps
`default_nettype none

`include "ic_cfg.svh"

module ic_addr_decode (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [`IC_ADDR_W-1:0] addr_i,
  input  logic                  accept_i,
  input  logic                  cache_en_i,
  ic_lookup_if.decode           lk
);
  import ic_pkg::*;

  logic [`IC_ADDR_W-1:0] addr_q;

  // held fetch address, loaded on the accept cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (accept_i) begin
      addr_q <= addr_i;
    end
  end

  // tag and offset only matter from the compare cycle on
  assign lk.tag    = addr_q[`IC_ADDR_W-1 -: IC_TAG_W];
  assign lk.offset = addr_q[IC_OFF_W-1:0];

  // arrays read on the accept edge, so the index bypasses the register
  assign lk.index = accept_i ? addr_i[IC_OFF_W +: IC_IDX_W] : addr_q[IC_OFF_W +: IC_IDX_W];

  // upper half of the address space is i/o
  // a disabled cache turns every fetch into an uncached one
  assign lk.nc = addr_q[`IC_ADDR_W-1] | ~cache_en_i;

endmodule

`default_nettype wire

//--- ic_cfg.svh
// cache geometry; sets and line bytes must be powers of two, the lfsr taps assume 8 bits
`ifndef IC_CFG_SVH
`define IC_CFG_SVH

////////////////////
// address and fetch
////////////////////

// physical address width, top bit selects the uncached region
`define IC_ADDR_W 32

// one fetch word
`define IC_FETCH_W 32

////////////////////
// geometry
////////////////////

// bytes per line, a refill carries one full line
`define IC_LINE_BYTES 16

// associativity
`define IC_WAYS 2

// sets per way
`define IC_SETS 16

// replacement lfsr
`define IC_LFSR_W 8

`endif

//--- ic_ctrl.sv
// one fetch in flight; flush_i is deferred to IDLE and enabling always goes through a full flush
`timescale 1ns/1ps
`default_nettype none

`include "ic_cfg.svh"

module ic_ctrl (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      en_i,
  input  logic      flush_i,
  input  logic      req_i,
  output logic      ready_o,
  output logic      valid_o,
  output logic      miss_o,
  output logic      mem_req_o,
  input  logic      mem_ack_i,
  input  logic      mem_rtrn_vld_i,
  output logic      accept_o,
  output logic      cache_en_o,
  ic_lookup_if.ctrl lk
);
  import ic_pkg::*;

  ic_state_e           state_d, state_q;
  logic                cache_en_d, cache_en_q;
  logic                flush_d, flush_q;
  logic [IC_IDX_W-1:0] flush_cnt_q;
  logic                flush_done;

  // last set of the sweep
  assign flush_done   = (flush_cnt_q == IC_IDX_W'(`IC_SETS - 1));
  assign lk.flush_idx = flush_cnt_q;
  assign accept_o     = ready_o & req_i;
  assign cache_en_o   = cache_en_q;

  always_comb begin
    state_d    = state_q;
    // dropping en_i disables right away, enabling waits for a flush
    cache_en_d = cache_en_q & en_i;
    flush_d    = flush_q | flush_i;
    ready_o    = 1'b0;
    valid_o    = 1'b0;
    miss_o     = 1'b0;
    mem_req_o  = 1'b0;
    lk.rd_en    = 1'b0;
    lk.wr_en    = 1'b0;
    lk.flush_en = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        lk.flush_en = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      // pending flush or a rising en_i win over new fetches
      IDLE: begin
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else begin
          ready_o = 1'b1;
          if (req_i) begin
            lk.rd_en = 1'b1;
            state_d  = READ;
          end
        end
      end
      // compare cycle; a hit may take the next fetch right away
      READ: begin
        if (lk.hit) begin
          valid_o = 1'b1;
          state_d = IDLE;
          if (!flush_d) begin
            ready_o = 1'b1;
            if (req_i) begin
              lk.rd_en = 1'b1;
              state_d  = READ;
            end
          end
        end else begin
          // a miss or uncached fetch holds the request until ack
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            // perf counter only sees real misses
            miss_o  = ~lk.nc;
            state_d = MISS;
          end
        end
      end
      // refill returns in a single cycle
      MISS: begin
        if (mem_rtrn_vld_i) begin
          valid_o  = 1'b1;
          lk.wr_en = ~lk.nc;
          state_d  = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      // wraps back to set 0 after the last set
      if (lk.flush_en) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
    end
  end

  // no memory traffic while the arrays are being cleared
  a_state_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q inside {FLUSH, IDLE, READ, MISS}) && !(state_q == FLUSH && mem_req_o)
  ) else $error("icache ctrl: illegal state or request during flush");

endmodule

`default_nettype wire

//--- ic_hit_select.sv
// purely combinational; uncached fetches never hit, so a refill word wins whenever hit is low
`timescale 1ns/1ps
`default_nettype none

`include "ic_cfg.svh"

module ic_hit_select (
  input  ic_pkg::ic_line_u          rtrn_line_i,
  output logic [`IC_FETCH_W-1:0]    data_o,
  ic_lookup_if.select               lk
);
  import ic_pkg::*;

  logic                    cmp_en;
  ic_way_mask_t            hit_vec;
  logic [IC_WAY_IDX_W-1:0] hit_idx;
  logic [IC_WSEL_W-1:0]    wsel;

  // compare only counts for cacheable fetches
  assign cmp_en = ~lk.nc;

  always_comb begin
    for (int w = 0; w < `IC_WAYS; w++) begin
      hit_vec[w] = cmp_en & lk.vld_rdata[w] & (lk.tag_rdata[w] == lk.tag);
    end
  end

  assign hit_idx = ic_first_set(hit_vec);
  assign lk.hit  = |hit_vec;

  // word within the line
  assign wsel = lk.offset[IC_OFF_W-1 -: IC_WSEL_W];

  // uncached words are placed at their line offset by memory too
  assign data_o = lk.hit ? lk.line_rdata[hit_idx].words[wsel] : rtrn_line_i.words[wsel];

  // a line is only ever allocated on a miss, so no tag can sit in two ways
  a_hit_onehot: assert property (
    @(posedge lk.clk_i) disable iff (!lk.rst_ni) cmp_en |-> $onehot0(hit_vec)
  ) else $error("icache select: tag hit in more than one way");

endmodule

`default_nettype wire

//--- ic_lookup_if.sv
// lookup path between the cache blocks; array read data is only fresh in the cycle after rd_en
`timescale 1ns/1ps
`default_nettype none

`include "ic_cfg.svh"

interface ic_lookup_if (
  input logic clk_i,
  input logic rst_ni
);
  import ic_pkg::*;

  // decoded fetch address
  logic [IC_TAG_W-1:0] tag;
  logic [IC_IDX_W-1:0] index;
  logic [IC_OFF_W-1:0] offset;
  logic                nc;

  // array control from the FSM
  logic                rd_en;
  logic                wr_en;
  logic                flush_en;
  logic [IC_IDX_W-1:0] flush_idx;

  // array read results with one entry per way
  logic [`IC_WAYS-1:0][IC_TAG_W-1:0] tag_rdata;
  ic_way_mask_t                      vld_rdata;
  ic_line_u [`IC_WAYS-1:0]           line_rdata;

  // compare result
  logic hit;

  modport decode (output tag, index, offset, nc);
  modport ctrl   (input nc, hit, output rd_en, wr_en, flush_en, flush_idx);
  modport store  (input rd_en, wr_en, flush_en, flush_idx, tag, index,
                  output tag_rdata, vld_rdata, line_rdata);
  modport select (input clk_i, rst_ni, tag, offset, nc, tag_rdata, vld_rdata, line_rdata,
                  output hit);

endinterface

`default_nettype wire

//--- ic_pkg.sv
// shared cache types; field widths are derived from the cfg macros, nothing here is tunable
`default_nettype none

`include "ic_cfg.svh"

package ic_pkg;

  // address split: tag | index | offset
  localparam int IC_LINE_W    = `IC_LINE_BYTES * 8;
  localparam int IC_OFF_W     = $clog2(`IC_LINE_BYTES);
  localparam int IC_IDX_W     = $clog2(`IC_SETS);
  localparam int IC_TAG_W     = `IC_ADDR_W - IC_IDX_W - IC_OFF_W;
  // words per line and the offset bits that pick one
  localparam int IC_WORDS     = IC_LINE_W / `IC_FETCH_W;
  localparam int IC_WSEL_W    = $clog2(IC_WORDS);
  localparam int IC_BYTE_W    = IC_OFF_W - IC_WSEL_W;
  localparam int IC_WAY_IDX_W = (`IC_WAYS > 1) ? $clog2(`IC_WAYS) : 1;

  // controller states
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ic_state_e;

  // one bit per way
  typedef logic [`IC_WAYS-1:0] ic_way_mask_t;

  // a line is written as one vector and read back word by word
  typedef union packed {
    logic [IC_LINE_W-1:0]                 flat;
    logic [IC_WORDS-1:0][`IC_FETCH_W-1:0] words;
  } ic_line_u;

  // lowest set bit of a way mask, 0 when empty
  function automatic logic [IC_WAY_IDX_W-1:0] ic_first_set(input ic_way_mask_t mask);
    logic [IC_WAY_IDX_W-1:0] idx;
    idx = '0;
    for (int w = `IC_WAYS - 1; w >= 0; w--) begin
      if (mask[w]) begin
        idx = IC_WAY_IDX_W'(w);
      end
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

//--- ic_way_store.sv
// tag, valid and line arrays with registered read; memories have no reset, FLUSH clears valid
`timescale 1ns/1ps
`default_nettype none

`include "ic_cfg.svh"

module ic_way_store (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  ic_pkg::ic_line_u rtrn_line_i,
  ic_lookup_if.store       lk
);
  import ic_pkg::*;

  // x^8 + x^6 + x^5 + x^4 + 1, right shifting
  localparam logic [`IC_LFSR_W-1:0] LFSR_TAPS = 'h1D;

  // valid bit sits above the tag
  logic [IC_TAG_W:0]    tagv_mem [`IC_WAYS][`IC_SETS];
  logic [IC_LINE_W-1:0] line_mem [`IC_WAYS][`IC_SETS];

  logic                    rd_q;
  logic                    all_vld, all_vld_q;
  logic [IC_WAY_IDX_W-1:0] inv_way, repl_way;
  ic_way_mask_t            repl_q;
  logic [`IC_LFSR_W-1:0]   lfsr_q;

  ////////////////////
  // arrays
  ////////////////////

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `IC_WAYS; w++) begin
      // flush sweep and refill never share a cycle
      if (lk.flush_en) begin
        tagv_mem[w][lk.flush_idx] <= '0;
      end else if (lk.wr_en && repl_q[w]) begin
        tagv_mem[w][lk.index] <= {1'b1, lk.tag};
        line_mem[w][lk.index] <= rtrn_line_i.flat;
      end
      if (lk.rd_en) begin
        lk.tag_rdata[w]       <= tagv_mem[w][lk.index][IC_TAG_W-1:0];
        lk.line_rdata[w].flat <= line_mem[w][lk.index];
      end
    end
  end

  // valid read port kept clean so the first compare sees no stale hit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lk.vld_rdata <= '0;
    end else if (lk.rd_en) begin
      for (int w = 0; w < `IC_WAYS; w++) begin
        lk.vld_rdata[w] <= tagv_mem[w][lk.index][IC_TAG_W];
      end
    end
  end

  ////////////////////
  // replacement
  ////////////////////

  // fill holes first, random once the set is full
  assign all_vld  = &lk.vld_rdata;
  assign inv_way  = ic_first_set(~lk.vld_rdata);
  assign repl_way = all_vld ? lfsr_q[IC_WAY_IDX_W-1:0] : inv_way;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q      <= 1'b0;
      all_vld_q <= 1'b0;
      repl_q    <= '0;
      lfsr_q    <= `IC_LFSR_W'(1);
    end else begin
      rd_q <= lk.rd_en;
      // victim latched at compare time, used by the later refill
      if (rd_q) begin
        repl_q    <= ic_way_mask_t'(1) << repl_way;
        all_vld_q <= all_vld;
      end
      // lfsr moves only when it actually picked the victim
      if (lk.wr_en && all_vld_q) begin
        lfsr_q <= {^(lfsr_q & LFSR_TAPS), lfsr_q[`IC_LFSR_W-1:1]};
      end
    end
  end

  // the FSM must keep refills out of the flush sweep
  a_no_wr_in_flush: assert property (
    @(posedge clk_i) disable iff (!rst_ni) lk.wr_en |-> !lk.flush_en
  ) else $error("icache store: refill write during flush");

endmodule

`default_nettype wire

//--- icache_top.sv
// fetch data must be taken with valid_o; refill returns carry a full line and are never stalled
`timescale 1ns/1ps
`default_nettype none

`include "ic_cfg.svh"

module icache_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       en_i,
  input  logic                       flush_i,
  // fetch port
  input  logic                       req_i,
  input  logic [`IC_ADDR_W-1:0]      addr_i,
  output logic                       ready_o,
  output logic                       valid_o,
  output logic [`IC_FETCH_W-1:0]     data_o,
  output logic                       miss_o,
  // refill port
  output logic                       mem_req_o,
  output logic [`IC_ADDR_W-1:0]      mem_addr_o,
  output logic                       mem_nc_o,
  input  logic                       mem_ack_i,
  input  logic                       mem_rtrn_vld_i,
  input  logic [`IC_LINE_BYTES*8-1:0] mem_rtrn_data_i
);
  import ic_pkg::*;

  logic     accept;
  logic     cache_en;
  ic_line_u rtrn_line;

  assign rtrn_line.flat = mem_rtrn_data_i;

  ic_lookup_if lk (.clk_i, .rst_ni);

  ic_addr_decode u_decode (
    .clk_i, .rst_ni, .addr_i,
    .accept_i   (accept),
    .cache_en_i (cache_en),
    .lk         (lk.decode)
  );

  ic_ctrl u_ctrl (
    .clk_i, .rst_ni, .en_i, .flush_i, .req_i, .ready_o, .valid_o, .miss_o,
    .mem_req_o, .mem_ack_i, .mem_rtrn_vld_i,
    .accept_o   (accept),
    .cache_en_o (cache_en),
    .lk         (lk.ctrl)
  );

  ic_way_store u_store (
    .clk_i, .rst_ni,
    .rtrn_line_i (rtrn_line),
    .lk          (lk.store)
  );

  ic_hit_select u_select (
    .rtrn_line_i (rtrn_line),
    .data_o,
    .lk          (lk.select)
  );

  // uncached fetches ask for one word, cached ones for the whole line
  always_comb begin
    if (lk.nc) begin
      mem_addr_o = {lk.tag, lk.index, lk.offset[IC_OFF_W-1 -: IC_WSEL_W], {IC_BYTE_W{1'b0}}};
    end else begin
      mem_addr_o = {lk.tag, lk.index, {IC_OFF_W{1'b0}}};
    end
  end

  assign mem_nc_o = lk.nc;

endmodule

`default_nettype wire

//--- project.f
+incdir+.
ic_pkg.sv
ic_lookup_if.sv
ic_addr_decode.sv
ic_ctrl.sv
ic_way_store.sv
ic_hit_select.sv
icache_top.sv
tb_clk_gen.sv
tb_icache.sv

//--- tb_clk_gen.sv
// free-running clock with a fixed reset pulse; reset is released 10 ns after a rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

  // active low reset, held for a whole number of cycles
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #10 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_icache.sv
// one fetch in flight at a time; memory answers every request, uncached too, with a full line
`timescale 1ns/1ps
`default_nettype none

`include "ic_cfg.svh"

module tb_icache;

  localparam int          CLK_PERIOD  = 100;
  localparam int          FETCH_COUNT = 21;
  // reset plus one flush sweep per enable or flush_i
  localparam int          SETUP_CYC   = 10 + 4 * `IC_SETS;
  localparam int          TIMEOUT_CYC = FETCH_COUNT * 20 + SETUP_CYC;
  localparam logic [31:0] SEED        = 32'h786d_5b4c;
  localparam logic [31:0] DATA_KEY    = 32'hA5A5_0000;

  logic                          clk;
  logic                          rst_n;
  logic                          en, flush, req, ready, valid, miss;
  logic [`IC_ADDR_W-1:0]         addr;
  logic [`IC_FETCH_W-1:0]        data;
  logic                          mem_req, mem_nc, mem_ack, mem_rtrn_vld;
  logic [`IC_ADDR_W-1:0]         mem_addr;
  logic [`IC_LINE_BYTES*8-1:0]   mem_rtrn_data;

  // expectations for the fetch in flight
  logic [31:0] exp_addr;
  logic        exp_nc;
  logic        expect_hit;
  logic        expect_miss;
  logic        accept;
  int          err_cnt;
  int          test_err_base;
  int          tests_run;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(10)) u_clk (.clk_o(clk), .rst_no(rst_n));

  icache_top u_dut (
    .clk_i(clk), .rst_ni(rst_n), .en_i(en), .flush_i(flush),
    .req_i(req), .addr_i(addr), .ready_o(ready), .valid_o(valid), .data_o(data),
    .miss_o(miss), .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_nc_o(mem_nc),
    .mem_ack_i(mem_ack), .mem_rtrn_vld_i(mem_rtrn_vld), .mem_rtrn_data_i(mem_rtrn_data)
  );

  // memory content: every word holds its own word address scrambled by a key
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {a[31:2], 2'b00} ^ DATA_KEY;
  endfunction

  // uncached requests are word aligned, cached ones line aligned
  function automatic logic [31:0] refill_addr(input logic [31:0] a, input logic nc);
    return nc ? {a[31:2], 2'b00} : {a[31:4], 4'h0};
  endfunction

  // whole line around an address, word 0 in the low bits
  function automatic logic [`IC_LINE_BYTES*8-1:0] mem_line(input logic [31:0] a);
    logic [`IC_LINE_BYTES*8-1:0] line;
    for (int i = 0; i < `IC_LINE_BYTES / 4; i++) begin
      line[32*i +: 32] = mem_word({a[31:4], 4'h0} + 32'(4 * i));
    end
    return line;
  endfunction

  assign accept = req & ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_addr <= '0;
      exp_nc   <= 1'b0;
    end else if (accept) begin
      exp_addr <= addr;
      exp_nc   <= addr[31] | ~en;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  a_flush_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !ready [* `IC_SETS] ##1 ready
  ) else begin
    err_cnt++;
    $display("at %0t ready_o did not rise exactly %0d cycles after reset", $time, `IC_SETS);
  end

  a_fetch_data: assert property (@(posedge clk) disable iff (!rst_n)
    valid |-> data == mem_word(exp_addr)
  ) else begin
    err_cnt++;
    $display("MISMATCH at %0t: data_o %h for address %h, expected %h", $time,
             $sampled(data), $sampled(exp_addr), mem_word($sampled(exp_addr)));
  end

  a_refill_addr: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req |-> mem_nc == exp_nc && mem_addr == refill_addr(exp_addr, exp_nc)
  ) else begin
    err_cnt++;
    $display("MISMATCH at %0t: refill address %h nc %b for fetch %h", $time,
             $sampled(mem_addr), $sampled(mem_nc), $sampled(exp_addr));
  end

  // perf pulse only in the ack cycle of a cacheable miss
  a_miss_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    miss == (mem_req && mem_ack && !exp_nc)
  ) else begin
    err_cnt++;
    $display("MISMATCH at %0t: miss_o is %b", $time, $sampled(miss));
  end

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_nc)
  ) else begin
    err_cnt++;
    $display("at %0t the refill request dropped or changed before its ack", $time);
  end

  a_hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
    accept && expect_hit |=> valid && !mem_req
  ) else begin
    err_cnt++;
    $display("at %0t a resident line did not return one cycle after accept", $time);
  end

  a_hit_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    expect_hit |-> !miss && !mem_req
  ) else begin
    err_cnt++;
    $display("at %0t memory traffic during fetches that should hit", $time);
  end

  // next fetch overlaps the returning hit
  a_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
    expect_hit && valid && req |-> ready
  ) else begin
    err_cnt++;
    $display("at %0t a back-to-back fetch was not taken in the hit cycle", $time);
  end

  a_miss_request: assert property (@(posedge clk) disable iff (!rst_n)
    accept && expect_miss |=> mem_req
  ) else begin
    err_cnt++;
    $display("at %0t no refill request one cycle after a fetch that must miss", $time);
  end

  ////////////////////
  // memory model
  ////////////////////

  initial begin : mem_model
    int unsigned dly;
    logic [31:0] line_addr;
    mem_ack       = 1'b0;
    mem_rtrn_vld  = 1'b0;
    mem_rtrn_data = '0;
    void'($urandom(SEED));
    forever begin
      @(posedge clk);
      #10;
      if (mem_req) begin
        // ack after 0 to 3 cycles
        dly = $urandom % 4;
        repeat (dly) begin
          @(posedge clk);
          #10;
        end
        mem_ack   = 1'b1;
        line_addr = mem_addr;
        @(posedge clk);
        #10;
        mem_ack = 1'b0;
        // line comes back 1 to 4 cycles after the ack
        dly = 1 + $urandom % 4;
        repeat (dly - 1) begin
          @(posedge clk);
          #10;
        end
        mem_rtrn_vld  = 1'b1;
        mem_rtrn_data = mem_line(line_addr);
        @(posedge clk);
        #10;
        mem_rtrn_vld = 1'b0;
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  // sequential words from base, each held until accepted, then wait for the last word
  task automatic fetch_seq(input logic [31:0] base, input int count);
    for (int i = 0; i < count; i++) begin
      req  = 1'b1;
      addr = base + 32'(4 * i);
      do begin
        @(negedge clk);
      end while (!ready);
      @(posedge clk);
      #10;
    end
    req = 1'b0;
    do begin
      @(negedge clk);
    end while (!valid);
    @(posedge clk);
    #10;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("test %0d %s: %s", tests_run, name, (err_cnt == test_err_base) ? "ok" : "errors");
    test_err_base = err_cnt;
  endtask

  initial begin : stimulus
    en            = 1'b1;
    flush         = 1'b0;
    req           = 1'b0;
    addr          = '0;
    expect_hit    = 1'b0;
    expect_miss   = 1'b0;
    err_cnt       = 0;
    test_err_base = 0;
    tests_run     = 0;

    wait (rst_n);
    do begin
      @(negedge clk);
    end while (!ready);
    @(posedge clk);
    #10;
    report_test("reset flush");

    expect_miss = 1'b1;
    fetch_seq(32'h0000_1234, 1);
    expect_miss = 1'b0;
    report_test("cold miss");

    expect_hit = 1'b1;
    fetch_seq(32'h0000_1230, 4);
    expect_hit = 1'b0;
    report_test("line hit");

    // i/o region, then a cached line while disabled
    expect_miss = 1'b1;
    fetch_seq(32'h8000_0048, 1);
    fetch_seq(32'h8000_0048, 1);
    en = 1'b0;
    @(posedge clk);
    #10;
    fetch_seq(32'h0000_1234, 1);
    fetch_seq(32'h0000_1234, 1);
    en          = 1'b1;
    expect_miss = 1'b0;
    report_test("uncached");

    // three lines on set 5 with only two ways
    repeat (3) begin
      for (int k = 0; k < 3; k++) begin
        fetch_seq(32'h0000_2050 + (32'(k) << 16), 1);
      end
    end
    fetch_seq(32'h0000_3060, 1);
    expect_hit = 1'b1;
    fetch_seq(32'h0000_3064, 1);
    expect_hit = 1'b0;
    flush      = 1'b1;
    @(posedge clk);
    #10;
    flush       = 1'b0;
    expect_miss = 1'b1;
    fetch_seq(32'h0000_3068, 1);
    expect_miss = 1'b0;
    report_test("set conflict and flush");

    $display("%0d tests run, %0d checks failed", tests_run, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYC);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
